//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int WORD_W   = 8;
    localparam int PC_W     = 24;
    localparam int ALU_OPS  = 5;
    localparam int ST_RAM_W = 10;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [PC_W-1:0]   pc_t;

    typedef struct packed {
        word_t opcode;
        word_t imm;
    } instr_t;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////
    typedef enum logic [7:0] {
        NOP     = 8'h00,
        LDI_A   = 8'h01,
        LDI_B   = 8'h02,
        LDI_C   = 8'h03,
        LDI_D   = 8'h04,
        LDR_A   = 8'h05,
        LDR_B   = 8'h06,
        LDR_C   = 8'h07,
        LDR_D   = 8'h08,
        LDB_A   = 8'h09,
        LDB_B   = 8'h0a,
        LDB_C   = 8'h0b,
        LDB_D   = 8'h0c,
        JZ      = 8'h0d,
        ALU_ADD = 8'h0e,
        ALU_MUL = 8'h0f,
        ALU_AND = 8'h10,
        ALU_OR  = 8'h11,
        ALU_XOR = 8'h12,
        STB     = 8'h13,
        STR_A   = 8'h14,
        STR_B   = 8'h15,
        STR_C   = 8'h16,
        STR_CY  = 8'h17,
        STR_SUM = 8'h18,
        STR_MH  = 8'h19,
        STR_ML  = 8'h1a,
        STR_AND = 8'h1b,
        STR_OR  = 8'h1c,
        STR_XOR = 8'h1d
    } opcode_e;

    // one strobe per action, index 0 is register A
    typedef struct packed {
        logic [3:0]          ld_imm;
        logic [3:0]          ld_ram;
        logic [3:0]          ld_bus;
        logic                jump;
        logic [ALU_OPS-1:0]  alu_op;
        logic                st_bus;
        logic                rd_bus;
        logic                rd_ram;
        logic [ST_RAM_W-1:0] st_ram;
    } cmd_t;

    typedef struct packed {
        logic [WORD_W:0]     sum;
        logic [2*WORD_W-1:0] prod;
        word_t               and_r;
        word_t               or_r;
        word_t               xor_r;
    } alu_res_t;

endpackage

`default_nettype wire

//--- hdl/cpu_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// data RAM port, execute stage on the master side
interface ram_if;
    import cpu_pkg::*;

    logic  wen;
    word_t waddr;
    word_t wdata;
    logic  ren;
    word_t raddr;
    word_t rdata;

    modport master (
        output wen, waddr, wdata, ren, raddr,
        input  rdata
    );

    modport slave (
        input  wen, waddr, wdata, ren, raddr,
        output rdata
    );
endinterface

// alu operands and results
interface alu_if;
    import cpu_pkg::*;

    logic [ALU_OPS-1:0] op;
    word_t              in1;
    word_t              in2;
    alu_res_t           res;

    modport master (
        output op, in1, in2,
        input  res
    );

    modport slave (
        input  op, in1, in2,
        output res
    );
endinterface

`default_nettype wire

//--- hdl/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  logic         clk,
    input  logic         reset,
    input  logic         instr_valid,
    input  logic         jump_en,
    input  cpu_pkg::pc_t jump_target,
    output cpu_pkg::pc_t pc
);

    // jump wins over the slot increment
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else if (jump_en)
        begin
            pc <= jump_target;
        end
        else if (instr_valid)
        begin
            pc <= pc + 1'b1;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // execute issues a single load pulse per JZ
    a_jump_single: assert property (
        @(posedge clk) disable iff (reset)
        jump_en |=> !jump_en
    ) else $error("jump_en held for more than one cycle");

endmodule

`default_nettype wire

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic            clk,
    input  logic            reset,
    input  logic            instr_valid,
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::cmd_t   cmd,
    output cpu_pkg::word_t  imm
);
    import cpu_pkg::*;

    cmd_t next_cmd;

    always_comb
    begin
        next_cmd = '0;
        if (instr_valid)
        begin
            case (instr.opcode)
                LDI_A:   next_cmd.ld_imm[0] = 1'b1;
                LDI_B:   next_cmd.ld_imm[1] = 1'b1;
                LDI_C:   next_cmd.ld_imm[2] = 1'b1;
                LDI_D:   next_cmd.ld_imm[3] = 1'b1;
                LDR_A:   next_cmd.ld_ram[0] = 1'b1;
                LDR_B:   next_cmd.ld_ram[1] = 1'b1;
                LDR_C:   next_cmd.ld_ram[2] = 1'b1;
                LDR_D:   next_cmd.ld_ram[3] = 1'b1;
                LDB_A:   next_cmd.ld_bus[0] = 1'b1;
                LDB_B:   next_cmd.ld_bus[1] = 1'b1;
                LDB_C:   next_cmd.ld_bus[2] = 1'b1;
                LDB_D:   next_cmd.ld_bus[3] = 1'b1;
                JZ:      next_cmd.jump = 1'b1;
                ALU_ADD: next_cmd.alu_op[0] = 1'b1;
                ALU_MUL: next_cmd.alu_op[1] = 1'b1;
                ALU_AND: next_cmd.alu_op[2] = 1'b1;
                ALU_OR:  next_cmd.alu_op[3] = 1'b1;
                ALU_XOR: next_cmd.alu_op[4] = 1'b1;
                STB:     next_cmd.st_bus = 1'b1;
                STR_A:   next_cmd.st_ram[0] = 1'b1;
                STR_B:   next_cmd.st_ram[1] = 1'b1;
                STR_C:   next_cmd.st_ram[2] = 1'b1;
                STR_CY:  next_cmd.st_ram[3] = 1'b1;
                STR_SUM: next_cmd.st_ram[4] = 1'b1;
                STR_MH:  next_cmd.st_ram[5] = 1'b1;
                STR_ML:  next_cmd.st_ram[6] = 1'b1;
                STR_AND: next_cmd.st_ram[7] = 1'b1;
                STR_OR:  next_cmd.st_ram[8] = 1'b1;
                STR_XOR: next_cmd.st_ram[9] = 1'b1;
                default: ;
            endcase
        end
        // read strobes ride along with their loads
        next_cmd.rd_bus = |next_cmd.ld_bus;
        next_cmd.rd_ram = |next_cmd.ld_ram;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cmd <= '0;
        end
        else
        begin
            cmd <= next_cmd;
        end
    end

    always_ff @(posedge clk)
    begin
        imm <= instr.imm;
    end

    // at most one action per instruction
    a_cmd_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({cmd.ld_imm, cmd.ld_ram, cmd.ld_bus, cmd.jump, cmd.alu_op,
                  cmd.st_bus, cmd.st_ram})
    ) else $error("command word is not one-hot");

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic clk,
    input  logic reset,
    alu_if.slave bus
);
    import cpu_pkg::*;

    logic [ALU_OPS-1:0] op_q;
    alu_res_t           next_res;

    // every result of the operand pair, every cycle
    always_comb
    begin
        next_res.sum   = {1'b0, bus.in1} + {1'b0, bus.in2};
        next_res.prod  = bus.in1 * bus.in2;
        next_res.and_r = bus.in1 & bus.in2;
        next_res.or_r  = bus.in1 | bus.in2;
        next_res.xor_r = bus.in1 ^ bus.in2;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            op_q <= '0;
        end
        else
        begin
            op_q <= bus.op;
        end
    end

    // results only move when an op comes through
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bus.res <= '0;
        end
        else if (|op_q)
        begin
            bus.res <= next_res;
        end
    end

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_DEPTH = 256
) (
    input  logic clk,
    ram_if.slave bus
);
    import cpu_pkg::*;

    word_t mem [RAM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (bus.wen)
            mem[bus.waddr] <= bus.wdata;
    end

    // raddr is D, which holds steady, so the read runs every cycle
    always_ff @(posedge clk)
    begin
        bus.rdata <= mem[bus.raddr];
    end

    ////////////////////////////////////////
    // address range
    ////////////////////////////////////////
    a_waddr_range: assert property (
        @(posedge clk) bus.wen |-> (int'(bus.waddr) < RAM_DEPTH)
    ) else $error("ram write address out of range");

    a_raddr_range: assert property (
        @(posedge clk) bus.ren |-> (int'(bus.raddr) < RAM_DEPTH)
    ) else $error("ram read address out of range");

endmodule

`default_nettype wire

//--- hdl/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::cmd_t  cmd,
    input  cpu_pkg::word_t imm,
    ram_if.master          ram,
    alu_if.master          alu,
    output logic           bus_wen,
    output logic           bus_ren,
    output cpu_pkg::word_t bus_waddr,
    output cpu_pkg::word_t bus_wdata,
    output cpu_pkg::word_t bus_raddr,
    input  cpu_pkg::word_t bus_rdata,
    output logic           jump_en,
    output cpu_pkg::pc_t   jump_target
);
    import cpu_pkg::*;

    word_t               regs [0:3];
    word_t               a;
    word_t               b;
    word_t               c;
    word_t               d;
    word_t               imm_q;
    logic [3:0]          imm_ld_q;
    logic [3:0]          bus_ld_q;
    logic [3:0]          ram_ld_q;
    logic [ST_RAM_W-1:0] st_ram_q;
    logic                jump_q;
    logic                wr_seen;
    word_t               ram_fwd;

    assign a = regs[0];
    assign b = regs[1];
    assign c = regs[2];
    assign d = regs[3];

    ////////////////////////////////////////
    // first stage: strobes delayed a cycle
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            imm_ld_q <= '0;
            bus_ld_q <= '0;
            ram_ld_q <= '0;
            st_ram_q <= '0;
            jump_q   <= 1'b0;
            bus_wen  <= 1'b0;
            bus_ren  <= 1'b0;
            ram.ren  <= 1'b0;
        end
        else
        begin
            imm_ld_q <= cmd.ld_imm;
            bus_ld_q <= cmd.ld_bus;
            ram_ld_q <= cmd.ld_ram;
            st_ram_q <= cmd.st_ram;
            jump_q   <= cmd.jump;
            bus_wen  <= cmd.st_bus;
            bus_ren  <= cmd.rd_bus;
            ram.ren  <= cmd.rd_ram;
        end
    end

    always_ff @(posedge clk)
    begin
        imm_q <= imm;
    end

    ////////////////////////////////////////
    // register file A to D
    ////////////////////////////////////////

    // waddr/wdata always hold the last write, so matching it is safe
    assign ram_fwd = (wr_seen && (ram.raddr == ram.waddr)) ? ram.wdata : ram.rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (imm_ld_q[i])
                    regs[i] <= imm_q;
                else if (bus_ld_q[i])
                    regs[i] <= bus_rdata;
                else if (ram_ld_q[i])
                    regs[i] <= ram_fwd;
            end
        end
    end

    ////////////////////////////////////////
    // ram stores, one extra stage
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ram.wen <= 1'b0;
            wr_seen <= 1'b0;
        end
        else
        begin
            ram.wen <= |st_ram_q;
            if (ram.wen)
                wr_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (|st_ram_q)
        begin
            ram.waddr <= d;
            if (st_ram_q[0])
                ram.wdata <= a;
            else if (st_ram_q[1])
                ram.wdata <= b;
            else if (st_ram_q[2])
                ram.wdata <= c;
            else if (st_ram_q[3])
                ram.wdata <= {7'b0, alu.res.sum[WORD_W]};
            else if (st_ram_q[4])
                ram.wdata <= alu.res.sum[WORD_W-1:0];
            else if (st_ram_q[5])
                ram.wdata <= alu.res.prod[2*WORD_W-1:WORD_W];
            else if (st_ram_q[6])
                ram.wdata <= alu.res.prod[WORD_W-1:0];
            else if (st_ram_q[7])
                ram.wdata <= alu.res.and_r;
            else if (st_ram_q[8])
                ram.wdata <= alu.res.or_r;
            else
                ram.wdata <= alu.res.xor_r;
        end
    end

    assign ram.raddr = d;

    // alu, bus and jump all read straight from the registers
    assign alu.op  = cmd.alu_op;
    assign alu.in1 = a;
    assign alu.in2 = b;

    assign bus_waddr = d;
    assign bus_wdata = a;
    assign bus_raddr = d;

    // jz taken only when D is zero at decision time
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            jump_en <= 1'b0;
        end
        else
        begin
            jump_en <= jump_q && (d == '0);
        end
    end

    always_ff @(posedge clk)
    begin
        jump_target <= {a, b, c};
    end

    a_one_load_source: assert property (
        @(posedge clk) disable iff (reset)
        ((imm_ld_q & bus_ld_q) | (imm_ld_q & ram_ld_q) | (bus_ld_q & ram_ld_q)) == '0
    ) else $error("two load sources target the same register");

endmodule

`default_nettype wire

//--- hdl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int RAM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            instr_valid,
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::pc_t    pc,
    output logic            bus_wen,
    output cpu_pkg::word_t  bus_waddr,
    output cpu_pkg::word_t  bus_wdata,
    output logic            bus_ren,
    output cpu_pkg::word_t  bus_raddr,
    input  cpu_pkg::word_t  bus_rdata
);
    import cpu_pkg::*;

    cmd_t  cmd;
    word_t imm;
    logic  jump_en;
    pc_t   jump_target;

    ram_if ram_bus ();
    alu_if alu_bus ();

    ////////////////////////////////////////
    // fetch and decode
    ////////////////////////////////////////
    program_counter u_pc (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc)
    );

    instr_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .cmd         (cmd),
        .imm         (imm)
    );

    ////////////////////////////////////////
    // execute and its blocks
    ////////////////////////////////////////
    execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .imm         (imm),
        .ram         (ram_bus.master),
        .alu         (alu_bus.master),
        .bus_wen     (bus_wen),
        .bus_ren     (bus_ren),
        .bus_waddr   (bus_waddr),
        .bus_wdata   (bus_wdata),
        .bus_raddr   (bus_raddr),
        .bus_rdata   (bus_rdata),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    alu u_alu (
        .clk   (clk),
        .reset (reset),
        .bus   (alu_bus.slave)
    );

    data_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_ram (
        .clk (clk),
        .bus (ram_bus.slave)
    );

endmodule

`default_nettype wire

//--- bench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int RAM_DEPTH   = 256;
    localparam int NUM_RANDOM  = 400;
    localparam int STROBE_WAIT = 6;

    logic   clk;
    logic   reset;
    logic   instr_valid;
    instr_t instr;
    pc_t    pc;
    logic   bus_wen;
    word_t  bus_waddr;
    word_t  bus_wdata;
    logic   bus_ren;
    word_t  bus_raddr;
    word_t  bus_rdata;

    integer seed;
    int     mismatches;
    int     failures;
    int     wen_pulses;
    int     ren_pulses;
    word_t  seen_waddr;
    word_t  seen_wdata;
    word_t  seen_raddr;

    // isa model state
    word_t    m_regs [0:3];
    word_t    m_ram [RAM_DEPTH];
    logic     m_ram_valid [RAM_DEPTH];
    alu_res_t m_res;
    pc_t      m_pc;

    opcode_e alu_ops [7] = '{ALU_ADD, ALU_ADD, ALU_MUL, ALU_MUL, ALU_AND, ALU_OR, ALU_XOR};
    opcode_e str_ops [7] = '{STR_CY, STR_SUM, STR_MH, STR_ML, STR_AND, STR_OR, STR_XOR};

    cpu_top #(
        .RAM_DEPTH (RAM_DEPTH)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .bus_wen     (bus_wen),
        .bus_waddr   (bus_waddr),
        .bus_wdata   (bus_wdata),
        .bus_ren     (bus_ren),
        .bus_raddr   (bus_raddr),
        .bus_rdata   (bus_rdata)
    );

    always #50 clk = ~clk;

    // bus responder, read data follows the address
    always @(negedge clk)
    begin
        bus_rdata = bus_raddr ^ 8'ha5;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    function automatic int random_gap();
        return 4 + ({$random(seed)} % 4);
    endfunction

    // one idle slot, outputs sampled while stable
    task automatic idle_cycle();
        @(negedge clk);
        instr_valid = 1'b0;
        instr = 16'($random(seed));
        if (bus_wen)
        begin
            wen_pulses++;
            seen_waddr = bus_waddr;
            seen_wdata = bus_wdata;
        end
        if (bus_ren)
        begin
            ren_pulses++;
            seen_raddr = bus_raddr;
        end
    endtask

    ////////////////////////////////////////
    // isa model
    ////////////////////////////////////////
    task automatic apply_model(input word_t opcode, input word_t imm);
        word_t d;
        pc_t   next_pc;
        d = m_regs[3];
        next_pc = m_pc + 1'b1;
        case (opcode)
            LDI_A, LDI_B, LDI_C, LDI_D: m_regs[2'(opcode - LDI_A)] = imm;
            LDR_A, LDR_B, LDR_C, LDR_D: m_regs[2'(opcode - LDR_A)] = m_ram[d];
            LDB_A, LDB_B, LDB_C, LDB_D: m_regs[2'(opcode - LDB_A)] = d ^ 8'ha5;
            JZ:
            begin
                if (d == 8'h00)
                    next_pc = {m_regs[0], m_regs[1], m_regs[2]};
            end
            ALU_ADD, ALU_MUL, ALU_AND, ALU_OR, ALU_XOR:
            begin
                // any op refreshes the whole result set
                m_res.sum   = {1'b0, m_regs[0]} + {1'b0, m_regs[1]};
                m_res.prod  = 16'(m_regs[0]) * 16'(m_regs[1]);
                m_res.and_r = m_regs[0] & m_regs[1];
                m_res.or_r  = m_regs[0] | m_regs[1];
                m_res.xor_r = m_regs[0] ^ m_regs[1];
            end
            STR_A:   m_ram[d] = m_regs[0];
            STR_B:   m_ram[d] = m_regs[1];
            STR_C:   m_ram[d] = m_regs[2];
            STR_CY:  m_ram[d] = {7'b0, m_res.sum[8]};
            STR_SUM: m_ram[d] = m_res.sum[7:0];
            STR_MH:  m_ram[d] = m_res.prod[15:8];
            STR_ML:  m_ram[d] = m_res.prod[7:0];
            STR_AND: m_ram[d] = m_res.and_r;
            STR_OR:  m_ram[d] = m_res.or_r;
            STR_XOR: m_ram[d] = m_res.xor_r;
            default: ;
        endcase
        if (opcode >= STR_A && opcode <= STR_XOR)
            m_ram_valid[d] = 1'b1;
        m_pc = next_pc;
    endtask

    ////////////////////////////////////////
    // issue one instruction plus its gap
    ////////////////////////////////////////
    task automatic run_instr(input word_t opcode, input word_t imm, input int gap);
        word_t exp_addr;
        word_t exp_data;
        int    wen_start;
        int    ren_start;
        int    n;
        logic  is_stb;
        logic  is_ldb;
        exp_addr  = m_regs[3];
        exp_data  = m_regs[0];
        is_stb    = (opcode == STB);
        is_ldb    = (opcode >= LDB_A && opcode <= LDB_D);
        wen_start = wen_pulses;
        ren_start = ren_pulses;
        instr_valid  = 1'b1;
        instr.opcode = opcode;
        instr.imm    = imm;
        apply_model(opcode, imm);
        n = 0;
        if (is_stb)
        begin
            while (wen_pulses == wen_start && n < STROBE_WAIT)
            begin
                idle_cycle();
                n++;
            end
            if (wen_pulses == wen_start)
            begin
                $display("at %0t the bus write strobe never came for STB", $time);
                failures++;
            end
            else
            begin
                check_value(seen_waddr, exp_addr, "STB bus_waddr");
                check_value(seen_wdata, exp_data, "STB bus_wdata");
            end
        end
        if (is_ldb)
        begin
            while (ren_pulses == ren_start && n < STROBE_WAIT)
            begin
                idle_cycle();
                n++;
            end
            if (ren_pulses == ren_start)
            begin
                $display("at %0t the bus read strobe never came for LDB", $time);
                failures++;
            end
            else
            begin
                check_value(seen_raddr, exp_addr, "LDB bus_raddr");
            end
        end
        while (n < gap)
        begin
            idle_cycle();
            n++;
        end
        check_value(wen_pulses - wen_start, is_stb, "bus_wen pulse count");
        check_value(ren_pulses - ren_start, is_ldb, "bus_ren pulse count");
        check_value(pc, m_pc, "pc after instruction");
    endtask

    task automatic pick_instr(output word_t opcode, output word_t imm);
        int r;
        r = {$random(seed)} % 40;
        if (r < 30)
            opcode = 8'(r);
        else if (r < 36)
            opcode = STB;
        else
            opcode = 8'h80 | 8'($random(seed));
        // zero immediates keep JZ taken now and then
        if ({$random(seed)} % 4 == 0)
            imm = 8'h00;
        else
            imm = 8'($random(seed));
        // never read a RAM byte that was not stored yet
        if (opcode >= LDR_A && opcode <= LDR_D && !m_ram_valid[m_regs[3]])
            opcode = STR_A;
    endtask

    initial
    begin
        word_t opcode;
        word_t imm;
        seed        = 32'h485c_2719;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        bus_rdata   = '0;
        mismatches  = 0;
        failures    = 0;
        wen_pulses  = 0;
        ren_pulses  = 0;
        for (int i = 0; i < 4; i++)
            m_regs[i] = '0;
        for (int i = 0; i < RAM_DEPTH; i++)
        begin
            m_ram[i]       = '0;
            m_ram_valid[i] = 1'b0;
        end
        m_res = '0;
        m_pc  = '0;

        repeat (4) @(negedge clk);
        reset = 1'b0;

        // quiet outputs right after reset
        repeat (4)
        begin
            idle_cycle();
            check_value(pc, 0, "pc after reset");
            check_value(bus_wen, 0, "bus_wen after reset");
            check_value(bus_ren, 0, "bus_ren after reset");
        end
        run_instr(STB, 8'h00, random_gap());

        ////////////////////////////////////////
        // every ALU result through the RAM
        ////////////////////////////////////////
        run_instr(LDI_A, 8'($random(seed)), random_gap());
        run_instr(LDI_B, 8'($random(seed)), random_gap());
        run_instr(LDI_D, 8'($random(seed)), random_gap());
        for (int k = 0; k < 7; k++)
        begin
            run_instr(alu_ops[k], 8'h00, random_gap());
            run_instr(str_ops[k], 8'h00, random_gap());
            run_instr(LDR_A, 8'h00, random_gap());
            run_instr(STB, 8'h00, random_gap());
        end

        // random program
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            pick_instr(opcode, imm);
            run_instr(opcode, imm, random_gap());
        end

        $display("summary: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/cpu_pkg.sv
hdl/cpu_ifs.sv
hdl/program_counter.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/data_ram.sv
hdl/execute.sv
hdl/cpu_top.sv
bench/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - hdl/cpu_pkg.sv
  - hdl/cpu_ifs.sv
  - hdl/program_counter.sv
  - hdl/instr_decoder.sv
  - hdl/alu.sv
  - hdl/data_ram.sv
  - hdl/execute.sv
  - hdl/cpu_top.sv
  - target: test
    files:
      - bench/tb_cpu.sv
